// File: sources.f
+incdir+logic
logic/pt2262_pkg.sv
logic/osc_tick.sv
logic/pt2262_addr_decode.sv
logic/pt2262_frame_seq.sv
logic/pt2262_pulse_shaper.sv
logic/pt2262_encoder.sv
bench/pt2262_encoder_tb.sv

// File: run_sim.sh
#!/bin/sh
# Builds the encoder testbench with Verilator, runs it and checks the log

BUILD_DIR=build
LOG="$BUILD_DIR/sim.log"

mkdir -p "$BUILD_DIR"
if [ $? -ne 0 ]; then
    echo "cannot create $BUILD_DIR"
    exit 1
fi

verilator --binary --timing --assert -Wno-fatal \
    --top-module pt2262_encoder_tb --Mdir "$BUILD_DIR" -o sim_tb -f sources.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"$BUILD_DIR/sim_tb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TESTBENCH PASSED" "$LOG"; then
    exit 0
fi
echo "pass message not found in $LOG"
exit 1

// File: bench/pt2262_encoder_tb.sv
`timescale 1ns/10ps
`include "pt2262_cfg.svh"

module pt2262_encoder_tb;

    localparam int DIV        = `PT_OSC_DIV;
    localparam int FRAME_LEN  = 12 * `PT_BIT_LEN + `PT_SYNC_LEN;   // Alpha per frame
    localparam int HALF_PULSE = `PT_BIT_LEN / 2;
    localparam int N_ROWS     = 8;
    localparam int N_HAND     = 4;                               // Rows written by hand
    localparam int IDLE_ALPHA = 40;

    typedef struct packed {
        pt2262_pkg::frame_word_t word;
        logic [2:0]              frames;   // Frames sent with this word
        logic                    drop;     // Send falls in the last frame
    } stim_row_t;

    logic                    clk = 1'b0;
    logic                    reset;
    logic                    send;
    pt2262_pkg::frame_word_t word;
    logic                    cod;
    logic                    sync;
    logic                    frame_done;

    stim_row_t               rows [N_ROWS];
    pt2262_pkg::frame_word_t exp_q [$];             // Words of frames still due
    logic [31:0]             lfsr = 32'h9415_7cc4;
    int                      limit_clocks = 0;
    int                      mismatch_cnt = 0;
    int                      fail_cnt = 0;

    // Waveform decoder state, counted in clk cycles
    int   high_cnt = 0;
    int   low_cnt = 0;
    int   sync_cnt = 0;          // Sync samples inside the open pulse
    int   first_kind = 0;        // First pulse of a code bit
    logic have_first = 1'b0;
    int   sym_idx = 0;           // Position within the frame, A0 is 0
    int   frames_seen = 0;
    int   cyc = 0;
    int   last_done_cyc = 0;
    logic last_done_valid = 1'b0;
    logic last_done_send = 1'b0; // Send seen by the DUT at the last frame_done

    pt2262_encoder pt2262_encoder_i (
        .clk        (clk),
        .reset      (reset),
        .send       (send),
        .word       (word),
        .cod        (cod),
        .sync       (sync),
        .frame_done (frame_done)
    );

    always #10 clk = ~clk;   // 20 ns period

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            mismatch_cnt++;
            $display("mismatch at %0t ns: %s is %0d, expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic report_failure(input string what);
        fail_cnt++;
        $display("error at %0t ns: %s", $time, what);
    endtask

    // Fibonacci LFSR, taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic draw_bits(input int n, output logic [31:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);              // One step per bit
            val  = {val[30:0], lfsr[0]};
        end
    endtask

    // Symbol idx of a frame: A0..A7, D3..D0, then sync
    function automatic pt2262_pkg::sym_t expected_symbol(input pt2262_pkg::frame_word_t w,
                                                         input int idx);
        pt2262_pkg::trit_code_t code;
        if (idx < 8) begin
            code = w.addr[2*idx +: 2];
            if (code == 2'b00) return pt2262_pkg::SYM_ZERO;
            if (code == 2'b01) return pt2262_pkg::SYM_ONE;
            return pt2262_pkg::SYM_F;           // 10 and 11 float
        end
        if (idx < 12) begin
            return w.data[11 - idx] ? pt2262_pkg::SYM_ONE : pt2262_pkg::SYM_ZERO;
        end
        return pt2262_pkg::SYM_SYNC;
    endfunction

    task automatic load_table();
        logic [31:0] r;
        rows[0] = '{word: '{addr: 16'hAAFF, data: 4'hA}, frames: 3'd2, drop: 1'b0};  // All F
        rows[1] = '{word: '{addr: 16'h0000, data: 4'h0}, frames: 3'd2, drop: 1'b1};  // All 0
        rows[2] = '{word: '{addr: 16'h5555, data: 4'hF}, frames: 3'd1, drop: 1'b0};  // All 1
        // A0..A7 = 0 1 F 1 0 F 1 0
        rows[3] = '{word: '{addr: 16'h1C64, data: 4'h6}, frames: 3'd2, drop: 1'b1};
        for (int i = N_HAND; i < N_ROWS; i++) begin
            draw_bits(16, r);
            rows[i].word.addr = r[15:0];
            draw_bits(4, r);
            rows[i].word.data = r[3:0];
            draw_bits(1, r);
            rows[i].frames = 3'd1 + r[0];
            draw_bits(1, r);
            rows[i].drop = r[0];
        end
        rows[N_ROWS-1].drop = 1'b1;   // Run ends idle
    endtask

    task automatic idle_check(input int n_alpha);
        repeat (n_alpha * DIV) begin
            @(negedge clk);
            check_value("cod", cod, 0);
            check_value("sync", sync, 0);
            check_value("frame_done", frame_done, 0);
        end
    endtask

    task automatic wait_frame_done();
        @(negedge clk);
        while (frame_done !== 1'b1) begin
            @(negedge clk);
        end
    endtask

    task automatic emit_symbol(input pt2262_pkg::sym_t kind);
        if (exp_q.size() == 0) begin
            report_failure("symbol on air while no frame was expected");
        end else begin
            check_value($sformatf("symbol %0d of frame %0d", sym_idx, frames_seen),
                        kind, expected_symbol(exp_q[0], sym_idx));
            if (kind == pt2262_pkg::SYM_SYNC || sym_idx == 12) begin
                void'(exp_q.pop_front());       // Frame closed
                sym_idx = 0;
                frames_seen++;
            end else begin
                sym_idx++;
            end
        end
    endtask

    // Classifies one high run plus the low run after it
    task automatic close_pulse(input logic at_done);
        int ha;
        int la;
        int kind;   // 0 short, 1 long, 2 sync, 3 no match
        ha = high_cnt / DIV;
        la = low_cnt / DIV;
        if (ha == `PT_SHORT && la == HALF_PULSE - `PT_SHORT) begin
            kind = 0;
        end else if (ha == `PT_LONG && la == HALF_PULSE - `PT_LONG) begin
            kind = 1;
        end else if (ha == `PT_SHORT && la == `PT_SYNC_LEN - `PT_SHORT) begin
            kind = 2;
        end else begin
            kind = 3;
        end
        if (kind == 2) begin
            check_value("sync high clocks", sync_cnt, `PT_SHORT * DIV);
            if (!at_done) report_failure("sync pulse ended without frame_done");
            if (have_first) report_failure("code bit cut off by the sync pulse");
            have_first = 1'b0;
            emit_symbol(pt2262_pkg::SYM_SYNC);
        end else if (kind == 3) begin
            report_failure($sformatf("pulse of %0d clocks high and %0d low fits no symbol",
                                     high_cnt, low_cnt));
            have_first = 1'b0;
        end else begin
            check_value("sync clocks in code bit", sync_cnt, 0);
            if (at_done) report_failure("frame_done outside the sync symbol");
            if (!have_first) begin
                first_kind = kind;
                have_first = 1'b1;
            end else begin
                have_first = 1'b0;
                if (first_kind == 0 && kind == 0) begin
                    emit_symbol(pt2262_pkg::SYM_ZERO);
                end else if (first_kind == 1 && kind == 1) begin
                    emit_symbol(pt2262_pkg::SYM_ONE);
                end else if (first_kind == 0 && kind == 1) begin
                    emit_symbol(pt2262_pkg::SYM_F);   // Short then long
                end else begin
                    report_failure("long pulse followed by a short one in one code bit");
                end
            end
        end
        high_cnt = 0;
        low_cnt  = 0;
        sync_cnt = 0;
    endtask

    initial begin
        wait (limit_clocks > 0);
        repeat (limit_clocks) @(posedge clk);
        $display("timeout: test did not end within %0d clocks", limit_clocks);
        $display("TESTBENCH FAILED");
        $finish;
    end

    // Outputs sampled mid cycle
    always @(negedge clk) begin
        if (!reset) begin
            cyc++;
            if (sync === 1'b1) check_value("cod while sync high", cod, 1);
            if (cod === 1'b1) begin
                if (high_cnt > 0 && low_cnt > 0) close_pulse(1'b0);   // Rising edge
                high_cnt++;
                if (sync === 1'b1) sync_cnt++;
            end else if (high_cnt > 0) begin
                low_cnt++;
            end
            if (frame_done === 1'b1) begin
                if (high_cnt > 0 && low_cnt > 0) begin
                    close_pulse(1'b1);            // Sync ends with the frame
                end else begin
                    report_failure("frame_done with no sync pulse before it");
                end
                if (last_done_valid && last_done_send) begin
                    check_value("frame_done spacing", cyc - last_done_cyc, FRAME_LEN * DIV);
                end
                last_done_cyc   = cyc;
                last_done_send  = send;
                last_done_valid = 1'b1;
            end
        end
    end

    initial begin
        int   total;
        logic pending;   // Frame of the previous row still on air
        reset   = 1'b1;
        send    = 1'b0;
        word    = '0;
        total   = 0;
        pending = 1'b0;
        load_table();
        for (int i = 0; i < N_ROWS; i++) begin
            total += rows[i].frames;
        end
        limit_clocks = (total * FRAME_LEN + 1000) * DIV;
        repeat (3) @(posedge clk);
        #2;
        reset = 1'b0;
        idle_check(IDLE_ALPHA);   // Send still low
        for (int r = 0; r < N_ROWS; r++) begin
            @(posedge clk);
            #2;
            word = rows[r].word;   // Mid frame if the last row kept send high
            send = 1'b1;
            for (int f = 0; f < rows[r].frames; f++) begin
                exp_q.push_back(rows[r].word);
            end
            if (pending) wait_frame_done();   // Old word finishes its frame
            for (int f = 0; f < rows[r].frames; f++) begin
                if (f < rows[r].frames - 1) begin
                    wait_frame_done();
                end else begin
                    repeat (FRAME_LEN / 2 * DIV) @(posedge clk);
                    #2;
                    pending = !rows[r].drop;
                    if (rows[r].drop) begin
                        send = 1'b0;       // Frame in progress must still complete
                        wait_frame_done();
                        idle_check(IDLE_ALPHA);
                    end
                end
            end
        end
        check_value("frames left", exp_q.size(), 0);
        check_value("frames seen", frames_seen, total);
        $display("%0d mismatches, %0d other errors, %0d of %0d frames checked",
                 mismatch_cnt, fail_cnt, frames_seen, total);
        if (mismatch_cnt == 0 && fail_cnt == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// File: logic/pt2262_encoder.sv
`timescale 1ns/10ps

// PT2262 style encoder top
module pt2262_encoder (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    send,
    input  pt2262_pkg::frame_word_t word,
    output logic                    cod,
    output logic                    sync,
    output logic                    frame_done
);

    logic                 tick;       // One alpha
    logic                 sym_done;
    pt2262_pkg::sym_cmd_t cmd;

    osc_tick u_tick (
        .clk   (clk),
        .reset (reset),
        .tick  (tick)
    );

    pt2262_frame_seq u_seq (
        .clk        (clk),
        .reset      (reset),
        .tick       (tick),
        .send       (send),
        .word       (word),
        .sym_done   (sym_done),
        .cmd        (cmd),
        .frame_done (frame_done)
    );

    pt2262_pulse_shaper u_shaper (
        .clk      (clk),
        .reset    (reset),
        .tick     (tick),
        .cmd      (cmd),
        .sym_done (sym_done),
        .cod      (cod),
        .sync     (sync)
    );

endmodule

// File: logic/pt2262_pulse_shaper.sv
`timescale 1ns/10ps
`include "pt2262_cfg.svh"

// Draws the on-air pattern of one symbol at a time
module pt2262_pulse_shaper (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 tick,
    input  pt2262_pkg::sym_cmd_t cmd,
    output logic                 sym_done,
    output logic                 cod,
    output logic                 sync
);

    localparam int CW       = $clog2(`PT_SYNC_LEN);
    localparam int HALF_LEN = `PT_BIT_LEN / 2;   // One pulse of a code bit

    logic             busy;
    pt2262_pkg::sym_t kind_q;     // Symbol being sent
    logic [CW-1:0]    acnt;       // Alpha within the current segment
    logic             half;       // Second pulse of a code bit
    logic [CW-1:0]    seg_last;
    logic [CW-1:0]    high_len;
    logic             is_sync;
    logic             seg_end;
    logic             sym_end;
    logic             start;

    assign is_sync = (kind_q == pt2262_pkg::SYM_SYNC);

    // Sync is one long segment, code bits are two halves
    assign seg_last = is_sync ? CW'(`PT_SYNC_LEN - 1) : CW'(HALF_LEN - 1);
    assign seg_end  = busy && tick && (acnt == seg_last);
    assign sym_end  = seg_end && (half || is_sync);
    assign start    = tick && cmd.valid && (!busy || sym_end);   // No gap between symbols
    assign sym_done = sym_end;

    always_comb begin
        // Long high for bit 1 and the second half of F
        if (kind_q == pt2262_pkg::SYM_ONE || (kind_q == pt2262_pkg::SYM_F && half)) begin
            high_len = CW'(`PT_LONG);
        end else begin
            high_len = CW'(`PT_SHORT);
        end
    end

    assign cod  = busy && (acnt < high_len);
    assign sync = busy && is_sync && (acnt < CW'(`PT_SHORT));   // Sync pin mirrors only the sync pulse

    always_ff @(posedge clk) begin
        if (reset) begin
            busy <= 1'b0;
            acnt <= '0;
            half <= 1'b0;
        end else if (start) begin
            busy <= 1'b1;
            acnt <= '0;
            half <= 1'b0;
        end else if (sym_end) begin
            busy <= 1'b0;          // Nothing queued, go quiet
        end else if (seg_end) begin
            acnt <= '0;
            half <= 1'b1;
        end else if (busy && tick) begin
            acnt <= acnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            kind_q <= cmd.kind;
        end
    end

    a_sync_in_cod: assert property (@(posedge clk) disable iff (reset)
        sync |-> cod);

endmodule

// File: logic/pt2262_frame_seq.sv
`timescale 1ns/10ps

// Walks the frame A0..A7, D3..D0, SYNC and feeds symbols to the shaper
module pt2262_frame_seq (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    tick,
    input  logic                    send,
    input  pt2262_pkg::frame_word_t word,
    input  logic                    sym_done,
    output pt2262_pkg::sym_cmd_t    cmd,
    output logic                    frame_done
);

    typedef enum logic [3:0] {
        ST_IDLE,
        ST_A0, ST_A1, ST_A2, ST_A3, ST_A4, ST_A5, ST_A6, ST_A7,
        ST_D3, ST_D2, ST_D1, ST_D0,
        ST_SYNC
    } seq_state_t;

    seq_state_t              state;
    seq_state_t              succ;        // State after the current symbol
    seq_state_t              cmd_state;   // Symbol shown on cmd
    pt2262_pkg::frame_word_t word_q;      // Word of the frame on air
    pt2262_pkg::frame_word_t dec_word;
    pt2262_pkg::addr_bits_t  addr_bits;
    logic [2:0]              a_idx;
    logic [1:0]              d_idx;
    logic                    frame_start;

    always_comb begin
        case (state)
            ST_IDLE: succ = ST_IDLE;
            ST_SYNC: succ = send ? ST_A0 : ST_IDLE;   // Repeat while send holds
            default: succ = seq_state_t'(state + 4'd1);
        endcase
    end

    // Next command is shown on the done tick so symbols run back to back
    assign cmd_state = sym_done ? succ : state;

    // A restarted frame takes A0 from the incoming word
    assign dec_word = (state == ST_SYNC) ? word : word_q;

    pt2262_addr_decode u_decode (
        .addr (dec_word.addr),
        .bits (addr_bits)
    );

    assign a_idx = 3'(cmd_state - ST_A0);
    assign d_idx = 2'(ST_D0 - cmd_state);   // D3 first

    always_comb begin
        cmd.valid = (cmd_state != ST_IDLE);
        if (cmd_state == ST_SYNC) begin
            cmd.kind = pt2262_pkg::SYM_SYNC;
        end else if (cmd_state >= ST_D3) begin
            // Data pins are never floating
            cmd.kind = dec_word.data[d_idx] ? pt2262_pkg::SYM_ONE : pt2262_pkg::SYM_ZERO;
        end else if (addr_bits.float_mask[a_idx]) begin
            cmd.kind = pt2262_pkg::SYM_F;
        end else begin
            cmd.kind = addr_bits.level[a_idx] ? pt2262_pkg::SYM_ONE : pt2262_pkg::SYM_ZERO;
        end
    end

    assign frame_done  = sym_done && (state == ST_SYNC);
    assign frame_start = (state == ST_IDLE && tick && send) || (frame_done && send);

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= ST_IDLE;
        end else if (state == ST_IDLE) begin
            if (tick && send) begin
                state <= ST_A0;
            end
        end else if (sym_done) begin
            state <= succ;
        end
    end

    // Word held for the whole frame
    always_ff @(posedge clk) begin
        if (frame_start) begin
            word_q <= word;
        end
    end

    a_idle_no_cmd: assert property (@(posedge clk) disable iff (reset)
        (state == ST_IDLE) |-> !cmd.valid);

    // Shaper paces the frame
    a_step_on_done: assert property (@(posedge clk) disable iff (reset)
        (state != ST_IDLE && !sym_done) |=> $stable(state));

endmodule

// File: logic/pt2262_addr_decode.sv
`timescale 1ns/10ps

// Splits the trit word into levels and an open-pin mask
module pt2262_addr_decode (
    input  pt2262_pkg::addr_word_t addr,
    output pt2262_pkg::addr_bits_t bits
);

    always_comb begin
        pt2262_pkg::trit_code_t code;

        for (int i = 0; i < 8; i++) begin
            code = addr[2*i +: 2];             // Pin i, A0 lowest
            bits.float_mask[i] = code[1];      // 10 and 11 both mean F
            // Low bit carries the level of a driven pin
            if (code[1]) begin
                bits.level[i] = 1'b0;
            end else begin
                bits.level[i] = code[0];
            end
        end
    end

endmodule

// File: logic/osc_tick.sv
`timescale 1ns/10ps
`include "pt2262_cfg.svh"

// Stands in for the RC oscillator, one alpha per tick
module osc_tick (
    input  logic clk,
    input  logic reset,
    output logic tick
);

    localparam int CW = $clog2(`PT_OSC_DIV + 1);

    logic [CW-1:0] cnt;   // Cycles left in this alpha

    always_ff @(posedge clk) begin
        if (reset) begin
            cnt  <= CW'(`PT_OSC_DIV - 1);
            tick <= 1'b0;
        end else if (cnt == '0) begin
            cnt  <= CW'(`PT_OSC_DIV - 1);   // Wrap and reload
            tick <= 1'b1;
        end else begin
            cnt  <= cnt - 1'b1;
            tick <= 1'b0;
        end
    end

    // One clk wide, never back to back
    a_tick_single: assert property (@(posedge clk) disable iff (reset)
        tick |=> !tick);

endmodule

// File: logic/pt2262_pkg.sv
package pt2262_pkg;

    typedef logic [1:0]  trit_code_t;   // 00 zero, 01 one, 1x floating
    typedef logic [15:0] addr_word_t;   // Eight trits, A0 in bits 1:0
    typedef logic [3:0]  data_word_t;   // D3 in the top bit

    // Symbol kind sent to the shaper
    typedef logic [1:0] sym_t;

    localparam sym_t SYM_ZERO = 2'b00;
    localparam sym_t SYM_ONE  = 2'b01;
    localparam sym_t SYM_F    = 2'b10;
    localparam sym_t SYM_SYNC = 2'b11;

    typedef struct packed {
        addr_word_t addr;
        data_word_t data;
    } frame_word_t;

    typedef struct packed {
        logic [7:0] level;        // Driven level per address pin
        logic [7:0] float_mask;   // Pin left open
    } addr_bits_t;

    typedef struct packed {
        logic valid;
        sym_t kind;
    } sym_cmd_t;

endpackage

// File: logic/pt2262_cfg.svh
`ifndef PT2262_CFG_SVH
`define PT2262_CFG_SVH

// clk cycles per oscillator period (one alpha)
`define PT_OSC_DIV 4

// Pulse high lengths in alpha
`define PT_SHORT 4
`define PT_LONG 12

// Code bit, two pulses of 16 alpha each
`define PT_BIT_LEN 32

// Sync symbol, short high then a long gap
`define PT_SYNC_LEN 128

`endif
